// File: design/puzzle_pkg.sv
`default_nettype none

package puzzle_pkg;

    // Character and dimension widths
    localparam int byte_width = 8;
    localparam int size_width = 8;

    // One face area holds the full product of two dimensions
    localparam int product_width = 2 * size_width;

    // Per-box area and the running total
    localparam int result_width = 32;

    // Fields per line: length, width, height
    localparam int field_count = 3;
    localparam int field_index_width = $clog2(field_count);
    localparam logic [field_index_width-1:0] last_field = field_index_width'(field_count - 1);

    // Decimal digit range
    localparam logic [byte_width-1:0] char_zero = 8'h30;
    localparam logic [byte_width-1:0] char_nine = 8'h39;

    // Field separator
    localparam logic [byte_width-1:0] char_x = 8'h78;

    // End of one box line
    localparam logic [byte_width-1:0] char_newline = 8'h0A;

    // End of the whole transmission
    localparam logic [byte_width-1:0] char_eot = 8'h04;

endpackage

`default_nettype wire

// File: design/tap_decoder.sv
`timescale 1ns/1ns
`default_nettype none

module tap_decoder (
    input  wire                               tck,
    input  wire                               arst_n,
    input  wire                               tdi,
    input  wire                               test_logic_reset,
    input  wire                               ir_is_user,
    input  wire                               shift_dr,
    input  wire                               update_dr,
    output logic                              valid,
    output logic [puzzle_pkg::byte_width-1:0] data
);

    logic [puzzle_pkg::byte_width-1:0] shift_reg;
    logic user_shift;
    logic user_update;

    // Only scans with the user instruction selected count
    assign user_shift  = ir_is_user && shift_dr;
    assign user_update = ir_is_user && update_dr;

    // Host sends LSB first, so new bits enter at the top
    always_ff @(posedge tck) begin
        if (user_shift) begin
            shift_reg <= {tdi, shift_reg[puzzle_pkg::byte_width-1:1]};
        end
    end

    // Byte handed on at update, held until the next one
    always_ff @(posedge tck) begin
        if (user_update) begin
            data <= shift_reg;
        end
    end

    // Strobe lasts exactly the cycle after update
    always_ff @(posedge tck or negedge arst_n) begin
        if (!arst_n) begin
            valid <= 1'b0;
        end else if (test_logic_reset) begin
            valid <= 1'b0;
        end else begin
            valid <= user_update;
        end
    end

endmodule

`default_nettype wire

// File: design/line_decoder.sv
`timescale 1ns/1ns
`default_nettype none

module line_decoder (
    input  wire                               tck,
    input  wire                               arst_n,
    input  wire                               test_logic_reset,
    input  wire                               inbound_valid,
    input  wire  [puzzle_pkg::byte_width-1:0] inbound_byte,
    output logic                              end_of_file,
    output logic                              size_valid,
    output logic [puzzle_pkg::size_width-1:0] length,
    output logic [puzzle_pkg::size_width-1:0] width,
    output logic [puzzle_pkg::size_width-1:0] height
);

    // Decimal accumulators, one per field of the current line
    logic [puzzle_pkg::size_width-1:0] field [puzzle_pkg::field_count];
    logic [puzzle_pkg::field_index_width-1:0] field_index;

    logic is_digit;
    logic is_separator;
    logic is_newline;
    logic is_eot;
    logic [puzzle_pkg::size_width-1:0] digit_value;
    logic [puzzle_pkg::size_width-1:0] field_next;

    // Byte classification
    always_comb begin
        is_digit = (inbound_byte >= puzzle_pkg::char_zero)
                && (inbound_byte <= puzzle_pkg::char_nine);
        is_separator = (inbound_byte == puzzle_pkg::char_x);
        is_newline = (inbound_byte == puzzle_pkg::char_newline);
        is_eot = (inbound_byte == puzzle_pkg::char_eot);
    end

    // Times ten plus digit, wrapping at the field width
    always_comb begin
        digit_value = inbound_byte - puzzle_pkg::char_zero;
        field_next = field[field_index] * 8'd10 + digit_value;
    end

    always_ff @(posedge tck or negedge arst_n) begin
        if (!arst_n) begin
            field_index <= '0;
            for (int i = 0; i < puzzle_pkg::field_count; i++) begin
                field[i] <= '0;
            end
        end else if (test_logic_reset) begin
            field_index <= '0;
            for (int i = 0; i < puzzle_pkg::field_count; i++) begin
                field[i] <= '0;
            end
        end else if (inbound_valid) begin
            if (is_digit) begin
                field[field_index] <= field_next;
            end else if (is_separator) begin
                // Extra separators stay on the last field
                if (field_index < puzzle_pkg::last_field) begin
                    field_index <= field_index + 1'b1;
                end
            end else if (is_newline) begin
                field_index <= '0;
                for (int i = 0; i < puzzle_pkg::field_count; i++) begin
                    field[i] <= '0;
                end
            end
        end
    end

    // Dimensions latched at the newline so the fields can start over
    always_ff @(posedge tck) begin
        if (inbound_valid && is_newline) begin
            length <= field[0];
            width  <= field[1];
            height <= field[2];
        end
    end

    always_ff @(posedge tck or negedge arst_n) begin
        if (!arst_n) begin
            size_valid  <= 1'b0;
            end_of_file <= 1'b0;
        end else if (test_logic_reset) begin
            size_valid  <= 1'b0;
            end_of_file <= 1'b0;
        end else begin
            size_valid <= inbound_valid && is_newline;
            // Sticky until the next reset
            if (inbound_valid && is_eot) begin
                end_of_file <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: design/area_compute.sv
`timescale 1ns/1ns
`default_nettype none

module area_compute (
    input  wire                                 tck,
    input  wire                                 arst_n,
    input  wire                                 size_valid,
    input  wire  [puzzle_pkg::size_width-1:0]   length,
    input  wire  [puzzle_pkg::size_width-1:0]   width,
    input  wire  [puzzle_pkg::size_width-1:0]   height,
    output logic                                area_valid,
    output logic [puzzle_pkg::result_width-1:0] area_value
);

    logic [puzzle_pkg::product_width-1:0] length_ext;
    logic [puzzle_pkg::product_width-1:0] width_ext;
    logic [puzzle_pkg::product_width-1:0] height_ext;

    // Stage 1 registers
    logic                                 face_valid;
    logic [puzzle_pkg::product_width-1:0] face_lw;
    logic [puzzle_pkg::product_width-1:0] face_wh;
    logic [puzzle_pkg::product_width-1:0] face_hl;

    // Stage 2 combinational terms
    logic [puzzle_pkg::product_width-1:0] smallest;
    logic [puzzle_pkg::result_width-1:0]  face_sum;
    logic [puzzle_pkg::result_width-1:0]  slack;

    // Widen first so each product keeps all its bits
    assign length_ext = {{puzzle_pkg::size_width{1'b0}}, length};
    assign width_ext  = {{puzzle_pkg::size_width{1'b0}}, width};
    assign height_ext = {{puzzle_pkg::size_width{1'b0}}, height};

    always_ff @(posedge tck) begin
        face_lw <= length_ext * width_ext;
        face_wh <= width_ext * height_ext;
        face_hl <= height_ext * length_ext;
    end

    // Smallest face is the slack added to the paper
    always_comb begin
        smallest = face_lw;
        if (face_wh < smallest) begin
            smallest = face_wh;
        end
        if (face_hl < smallest) begin
            smallest = face_hl;
        end
    end

    always_comb begin
        face_sum = {{(puzzle_pkg::result_width - puzzle_pkg::product_width){1'b0}}, face_lw}
                 + {{(puzzle_pkg::result_width - puzzle_pkg::product_width){1'b0}}, face_wh}
                 + {{(puzzle_pkg::result_width - puzzle_pkg::product_width){1'b0}}, face_hl};
        slack = {{(puzzle_pkg::result_width - puzzle_pkg::product_width){1'b0}}, smallest};
    end

    always_ff @(posedge tck) begin
        area_value <= (face_sum << 1) + slack;
    end

    // Valid bits track the two boxes that may be in flight
    always_ff @(posedge tck or negedge arst_n) begin
        if (!arst_n) begin
            face_valid <= 1'b0;
            area_valid <= 1'b0;
        end else begin
            face_valid <= size_valid;
            area_valid <= face_valid;
        end
    end

endmodule

`default_nettype wire

// File: design/tap_encoder.sv
`timescale 1ns/1ns
`default_nettype none

module tap_encoder (
    input  wire                                 tck,
    input  wire                                 arst_n,
    input  wire                                 test_logic_reset,
    input  wire                                 ir_is_user,
    input  wire                                 capture_dr,
    input  wire                                 shift_dr,
    input  wire                                 valid,
    input  wire  [puzzle_pkg::result_width-1:0] data,
    output logic                                tdo
);

    logic [puzzle_pkg::result_width-1:0] shift_reg;
    logic user_capture;
    logic user_shift;

    assign user_capture = ir_is_user && capture_dr;
    assign user_shift   = ir_is_user && shift_dr;

    always_ff @(posedge tck or negedge arst_n) begin
        if (!arst_n) begin
            shift_reg <= '0;
        end else if (test_logic_reset) begin
            shift_reg <= '0;
        end else if (user_capture) begin
            // Nothing to report until the total is final
            shift_reg <= valid ? data : '0;
        end else if (user_shift) begin
            shift_reg <= {1'b0, shift_reg[puzzle_pkg::result_width-1:1]};
        end
    end

    // LSB leads, visible right after capture
    assign tdo = shift_reg[0];

endmodule

`default_nettype wire

// File: design/user_logic.sv
`timescale 1ns/1ns
`default_nettype none

module user_logic (
    input  wire  tck,
    input  wire  arst_n,
    input  wire  tdi,
    input  wire  test_logic_reset,
    // Accepted for TAP compatibility, not needed here
    input  wire  run_test_idle,
    input  wire  ir_is_user,
    input  wire  capture_dr,
    input  wire  shift_dr,
    input  wire  update_dr,
    output logic tdo
);

    // Inbound bytes from the TAP
    logic                              inbound_valid;
    logic [puzzle_pkg::byte_width-1:0] inbound_data;

    // Decoded box dimensions
    logic                              end_of_file;
    logic                              size_valid;
    logic [puzzle_pkg::size_width-1:0] length;
    logic [puzzle_pkg::size_width-1:0] width;
    logic [puzzle_pkg::size_width-1:0] height;

    // Per-box area
    logic                                area_valid;
    logic [puzzle_pkg::result_width-1:0] area_value;

    // Running total toward the TAP
    logic                                outbound_valid;
    logic [puzzle_pkg::result_width-1:0] outbound_data;

    tap_decoder tap_decoder_inst (
        .tck              (tck),
        .arst_n           (arst_n),
        .tdi              (tdi),
        .test_logic_reset (test_logic_reset),
        .ir_is_user       (ir_is_user),
        .shift_dr         (shift_dr),
        .update_dr        (update_dr),
        .valid            (inbound_valid),
        .data             (inbound_data)
    );

    line_decoder line_decoder_inst (
        .tck              (tck),
        .arst_n           (arst_n),
        .test_logic_reset (test_logic_reset),
        .inbound_valid    (inbound_valid),
        .inbound_byte     (inbound_data),
        .end_of_file      (end_of_file),
        .size_valid       (size_valid),
        .length           (length),
        .width            (width),
        .height           (height)
    );

    area_compute area_compute_inst (
        .tck        (tck),
        .arst_n     (arst_n),
        .size_valid (size_valid),
        .length     (length),
        .width      (width),
        .height     (height),
        .area_valid (area_valid),
        .area_value (area_value)
    );

    // Accumulator, one box per strobe
    always_ff @(posedge tck or negedge arst_n) begin
        if (!arst_n) begin
            outbound_data  <= '0;
            outbound_valid <= 1'b0;
        end else if (test_logic_reset) begin
            outbound_data  <= '0;
            outbound_valid <= 1'b0;
        end else begin
            if (area_valid) begin
                outbound_data <= outbound_data + area_value;
            end
            // Total readable only once EOT has been seen
            outbound_valid <= end_of_file;
        end
    end

    tap_encoder tap_encoder_inst (
        .tck              (tck),
        .arst_n           (arst_n),
        .test_logic_reset (test_logic_reset),
        .ir_is_user       (ir_is_user),
        .capture_dr       (capture_dr),
        .shift_dr         (shift_dr),
        .valid            (outbound_valid),
        .data             (outbound_data),
        .tdo              (tdo)
    );

endmodule

`default_nettype wire

// File: dv/user_logic_tb.sv
`timescale 1ns/1ns
`default_nettype none

module user_logic_tb;

    // Watchdog budget in bytes and reads
    localparam int random_boxes = 40;
    localparam int byte_budget = random_boxes * 12 + 80;
    localparam int read_budget = 8;
    localparam int timeout_cycles = byte_budget * 12 + read_budget * 40 + 200;

    // Cycles from the EOT update until the total is readable
    localparam int drain_cycles = 4;

    logic tck;
    logic arst_n;
    logic tdi;
    logic test_logic_reset;
    logic run_test_idle;
    logic ir_is_user;
    logic capture_dr;
    logic shift_dr;
    logic update_dr;
    wire  tdo;

    int seed = 72;
    int pass_count = 0;
    int fail_count = 0;
    logic [31:0] model_total;

    user_logic user_logic_inst (
        .tck              (tck),
        .arst_n           (arst_n),
        .tdi              (tdi),
        .test_logic_reset (test_logic_reset),
        .run_test_idle    (run_test_idle),
        .ir_is_user       (ir_is_user),
        .capture_dr       (capture_dr),
        .shift_dr         (shift_dr),
        .update_dr        (update_dr),
        .tdo              (tdo)
    );

    initial begin
        tck = 1'b0;
        forever #10 tck = ~tck;
    end

    // Wrapping paper for one box with dimensions taken modulo 256
    function automatic logic [31:0] box_area(input int l, input int w, input int h);
        int lm, wm, hm;
        int lw, wh, hl;
        int smallest;
        lm = l % 256;
        wm = w % 256;
        hm = h % 256;
        lw = lm * wm;
        wh = wm * hm;
        hl = hm * lm;
        smallest = lw;
        if (wh < smallest) smallest = wh;
        if (hl < smallest) smallest = hl;
        return 32'(2 * (lw + wh + hl) + smallest);
    endfunction

    task automatic idle_cycles(input int count);
        repeat (count) @(posedge tck);
    endtask

    // One DR scan of 8 shifts LSB first, then update and one idle cycle
    task automatic send_byte(input logic [7:0] value, input logic user);
        for (int i = 0; i < 8; i++) begin
            @(posedge tck);
            ir_is_user <= user;
            shift_dr   <= 1'b1;
            tdi        <= value[i];
        end
        @(posedge tck);
        shift_dr  <= 1'b0;
        update_dr <= 1'b1;
        @(posedge tck);
        update_dr  <= 1'b0;
        ir_is_user <= 1'b1;
    endtask

    task automatic send_number(input int value);
        logic [7:0] digits[$];
        int rest;
        rest = value;
        do begin
            digits.push_front(8'(rest % 10) + puzzle_pkg::char_zero);
            rest = rest / 10;
        end while (rest > 0);
        foreach (digits[i]) begin
            send_byte(digits[i], 1'b1);
        end
    endtask

    // Occasional space or carriage return
    task automatic maybe_noise(input bit noisy);
        if (noisy && (($random(seed) & 3) == 0)) begin
            if ($random(seed) & 1) send_byte(8'h20, 1'b1);
            else send_byte(8'h0D, 1'b1);
        end
    endtask

    task automatic send_box(input int l, input int w, input int h, input bit noisy);
        send_number(l);
        maybe_noise(noisy);
        send_byte(puzzle_pkg::char_x, 1'b1);
        send_number(w);
        maybe_noise(noisy);
        send_byte(puzzle_pkg::char_x, 1'b1);
        send_number(h);
        maybe_noise(noisy);
        send_byte(puzzle_pkg::char_newline, 1'b1);
        model_total = model_total + box_area(l, w, h);
    endtask

    task automatic send_eot();
        send_byte(puzzle_pkg::char_eot, 1'b1);
        idle_cycles(drain_cycles);
    endtask

    // Single-cycle TLR pulse that also restarts the model
    task automatic clear_state();
        @(posedge tck);
        test_logic_reset <= 1'b1;
        @(posedge tck);
        test_logic_reset <= 1'b0;
        model_total = '0;
    endtask

    // Capture then 32 shifts with tdo sampled mid-cycle before each shift edge
    task automatic read_result(output logic [31:0] word);
        @(posedge tck);
        capture_dr <= 1'b1;
        @(posedge tck);
        capture_dr <= 1'b0;
        shift_dr   <= 1'b1;
        for (int i = 0; i < 32; i++) begin
            @(negedge tck);
            word[i] = tdo;
            @(posedge tck);
        end
        shift_dr <= 1'b0;
    endtask

    task automatic check_total(input string name, input logic [31:0] expected);
        logic [31:0] tdo_word;
        read_result(tdo_word);
        assert (tdo_word == expected) begin
            pass_count++;
            $display("%s passed, tdo_word = %h", name, tdo_word);
        end else begin
            fail_count++;
            $display("MISMATCH tdo_word expected %h actual %h", expected, tdo_word);
            $display("%s failed", name);
        end
    endtask

    initial begin
        repeat (timeout_cycles) @(posedge tck);
        $display("Timeout after %0d cycles, the run did not complete", timeout_cycles);
        $display("Test FAILED");
        $finish;
    end

    initial begin
        arst_n           = 1'b0;
        tdi              = 1'b0;
        test_logic_reset = 1'b0;
        run_test_idle    = 1'b0;
        ir_is_user       = 1'b1;
        capture_dr       = 1'b0;
        shift_dr         = 1'b0;
        update_dr        = 1'b0;
        model_total      = '0;
        repeat (3) @(posedge tck);
        arst_n <= 1'b1;
        @(posedge tck);

        // Box already summed but nothing readable before EOT
        send_box(2, 3, 4, 1'b0);
        check_total("reset_no_eot", 32'd0);
        send_eot();
        check_total("box_2x3x4", 32'd58);
        clear_state();
        send_box(1, 1, 10, 1'b0);
        send_eot();
        check_total("box_1x1x10", 32'd43);

        clear_state();
        for (int i = 0; i < random_boxes; i++) begin
            send_box(1 + ($unsigned($random(seed)) % 30), 1 + ($unsigned($random(seed)) % 30),
                     1 + ($unsigned($random(seed)) % 30), 1'b1);
        end
        send_eot();
        check_total("random_boxes", model_total);

        // A digit scanned with another instruction must be dropped
        clear_state();
        send_number(4);
        send_byte(puzzle_pkg::char_x, 1'b1);
        send_number(5);
        send_byte(8'h37, 1'b0);
        send_byte(puzzle_pkg::char_x, 1'b1);
        send_number(6);
        send_byte(puzzle_pkg::char_newline, 1'b1);
        model_total = model_total + box_area(4, 5, 6);
        send_box(9, 2, 7, 1'b0);
        send_eot();
        check_total("non_user_scan", model_total);

        // TLR in the middle of a line
        clear_state();
        send_box(8, 8, 8, 1'b0);
        send_number(5);
        send_byte(puzzle_pkg::char_x, 1'b1);
        send_number(6);
        clear_state();
        send_box(3, 7, 2, 1'b0);
        send_box(11, 4, 9, 1'b0);
        check_total("tlr_before_eot", 32'd0);
        send_eot();
        check_total("tlr_fresh_list", model_total);

        clear_state();
        send_box(300, 2, 2, 1'b0);
        send_box(7, 260, 3, 1'b0);
        send_eot();
        check_total("wrap_modulo_256", model_total);

        $display("Checks passed %0d, failed %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: project.f
design/puzzle_pkg.sv
design/tap_decoder.sv
design/line_decoder.sv
design/area_compute.sv
design/tap_encoder.sv
design/user_logic.sv
dv/user_logic_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build the testbench with Verilator and run it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 \
    --top-module user_logic_tb \
    -f project.f \
    -o user_logic_sim \
    && ./obj_dir/user_logic_sim | tee /dev/stderr | grep -x "Test OK" > /dev/null \
    && exit 0 \
    || exit 1
